/* rtl/color_tracker_pkg.sv */
`default_nettype none

package color_tracker_pkg;

  // stream widths
  localparam int hcount_width = 11; // pixel column
  localparam int vcount_width = 10; // pixel row
  localparam int pixel_width  = 16; // rgb565 word
  localparam int chan_width   = 4;  // thresholded intensity

  // centre of mass arithmetic
  localparam int sum_width   = 32; // frame sums, divider operands
  localparam int count_width = 17; // masked pixel count
  localparam int num_axes    = 2;  // lane 0 is x, lane 1 is y

  // pipeline depths
  localparam int conv_latency = 3; // through ycrcb_converter
  localparam int mask_latency = 4; // pixel_valid to mask_valid

  // channel select codes; 6 and 7 give zero intensity
  localparam logic [2:0] chan_r  = 3'd0;
  localparam logic [2:0] chan_g  = 3'd1;
  localparam logic [2:0] chan_b  = 3'd2;
  localparam logic [2:0] chan_y  = 3'd3;
  localparam logic [2:0] chan_cr = 3'd4;
  localparam logic [2:0] chan_cb = 3'd5;

  // conversion weights, magnitudes only, signs live in the sums
  localparam int coef_y_r  = 77;
  localparam int coef_y_g  = 150;
  localparam int coef_y_b  = 29;
  localparam int coef_cr_r = 128; // +
  localparam int coef_cr_g = 107; // -
  localparam int coef_cr_b = 21;  // -
  localparam int coef_cb_r = 43;  // -
  localparam int coef_cb_g = 85;  // -
  localparam int coef_cb_b = 128; // +
  localparam int chroma_offset = 128; // recentres cr and cb

endpackage

`default_nettype wire

/* rtl/ycrcb_converter.sv */
`timescale 1ns/1ns
`default_nettype none

module ycrcb_converter (
  input  wire                                       clk_65mhz,
  input  wire                                       sys_rst,
  input  wire                                       in_valid,
  input  wire  [color_tracker_pkg::pixel_width-1:0]  in_pixel,
  input  wire  [color_tracker_pkg::hcount_width-1:0] in_hcount,
  input  wire  [color_tracker_pkg::vcount_width-1:0] in_vcount,
  output logic                                      out_valid,
  output logic [color_tracker_pkg::pixel_width-1:0]  out_pixel,
  output logic [color_tracker_pkg::hcount_width-1:0] out_hcount,
  output logic [color_tracker_pkg::vcount_width-1:0] out_vcount,
  output logic [7:0]                                y,
  output logic [7:0]                                cr,
  output logic [7:0]                                cb
);

  localparam int lat = color_tracker_pkg::conv_latency;

  logic [7:0] r8, g8, b8; // fields widened to 8 bits
  logic [15:0] p_y_r, p_y_g, p_y_b; // stage 1 products
  logic [15:0] p_cr_r, p_cr_g, p_cr_b;
  logic [15:0] p_cb_r, p_cb_g, p_cb_b;
  logic [15:0] y_sum; // max 64088, no overflow
  logic signed [17:0] cr_sum, cb_sum; // stage 2, signed
  logic [lat-1:0] valid_dly;
  logic [color_tracker_pkg::pixel_width-1:0]  pixel_dly  [lat];
  logic [color_tracker_pkg::hcount_width-1:0] hcount_dly [lat];
  logic [color_tracker_pkg::vcount_width-1:0] vcount_dly [lat];

  assign r8 = {in_pixel[15:11], 3'b000};
  assign g8 = {in_pixel[10:5], 2'b00};
  assign b8 = {in_pixel[4:0], 3'b000};

  // stage 1, products
  always_ff @(posedge clk_65mhz) begin
    p_y_r  <= 16'(r8 * color_tracker_pkg::coef_y_r);
    p_y_g  <= 16'(g8 * color_tracker_pkg::coef_y_g);
    p_y_b  <= 16'(b8 * color_tracker_pkg::coef_y_b);
    p_cr_r <= 16'(r8 * color_tracker_pkg::coef_cr_r);
    p_cr_g <= 16'(g8 * color_tracker_pkg::coef_cr_g);
    p_cr_b <= 16'(b8 * color_tracker_pkg::coef_cr_b);
    p_cb_r <= 16'(r8 * color_tracker_pkg::coef_cb_r);
    p_cb_g <= 16'(g8 * color_tracker_pkg::coef_cb_g);
    p_cb_b <= 16'(b8 * color_tracker_pkg::coef_cb_b);
  end

  // stage 2, sums
  always_ff @(posedge clk_65mhz) begin
    y_sum  <= p_y_r + p_y_g + p_y_b;
    cr_sum <= $signed({2'b00, p_cr_r}) - $signed({2'b00, p_cr_g}) - $signed({2'b00, p_cr_b});
    cb_sum <= $signed({2'b00, p_cb_b}) - $signed({2'b00, p_cb_r}) - $signed({2'b00, p_cb_g});
  end

  // stage 3, scale back and recentre chroma
  always_ff @(posedge clk_65mhz) begin
    y  <= y_sum[15:8];
    cr <= 8'((cr_sum >>> 8) + color_tracker_pkg::chroma_offset);
    cb <= 8'((cb_sum >>> 8) + color_tracker_pkg::chroma_offset);
  end

  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      valid_dly <= '0;
    end else begin
      valid_dly <= {valid_dly[lat-2:0], in_valid};
    end
  end

  // raw word and coordinates ride alongside the math
  always_ff @(posedge clk_65mhz) begin
    pixel_dly[0]  <= in_pixel;
    hcount_dly[0] <= in_hcount;
    vcount_dly[0] <= in_vcount;
    for (int i = 1; i < lat; i++) begin
      pixel_dly[i]  <= pixel_dly[i-1];
      hcount_dly[i] <= hcount_dly[i-1];
      vcount_dly[i] <= vcount_dly[i-1];
    end
  end

  assign out_valid  = valid_dly[lat-1];
  assign out_pixel  = pixel_dly[lat-1];
  assign out_hcount = hcount_dly[lat-1];
  assign out_vcount = vcount_dly[lat-1];

endmodule

`default_nettype wire

/* rtl/channel_threshold.sv */
`timescale 1ns/1ns
`default_nettype none

module channel_threshold (
  input  wire                                       clk_65mhz,
  input  wire                                       sys_rst,
  input  wire                                       in_valid,
  input  wire  [color_tracker_pkg::pixel_width-1:0]  in_pixel,
  input  wire  [color_tracker_pkg::hcount_width-1:0] in_hcount,
  input  wire  [color_tracker_pkg::vcount_width-1:0] in_vcount,
  input  wire  [7:0]                                y,
  input  wire  [7:0]                                cr,
  input  wire  [7:0]                                cb,
  input  wire  [2:0]                                chan_sel,
  input  wire  [color_tracker_pkg::chan_width-1:0]   lower_bound,
  input  wire  [color_tracker_pkg::chan_width-1:0]   upper_bound,
  output logic                                      mask_valid,
  output logic                                      mask,
  output logic [color_tracker_pkg::hcount_width-1:0] mask_hcount,
  output logic [color_tracker_pkg::vcount_width-1:0] mask_vcount
);

  logic [color_tracker_pkg::chan_width-1:0] intensity; // top nibble of chosen channel
  logic in_range;

  always_comb begin
    case (chan_sel)
      color_tracker_pkg::chan_r:  intensity = in_pixel[15:12]; // top of r5
      color_tracker_pkg::chan_g:  intensity = in_pixel[10:7];  // top of g6
      color_tracker_pkg::chan_b:  intensity = in_pixel[4:1];   // top of b5
      color_tracker_pkg::chan_y:  intensity = y[7:4];
      color_tracker_pkg::chan_cr: intensity = cr[7:4];
      color_tracker_pkg::chan_cb: intensity = cb[7:4];
      default:                    intensity = '0; // unused codes
    endcase
  end

  // both bounds inclusive, lower above upper masks nothing
  assign in_range = (intensity >= lower_bound) && (intensity <= upper_bound);

  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      mask_valid <= 1'b0;
    end else begin
      mask_valid <= in_valid;
    end
  end

  always_ff @(posedge clk_65mhz) begin
    mask        <= in_range;
    mask_hcount <= in_hcount;
    mask_vcount <= in_vcount;
  end

endmodule

`default_nettype wire

/* rtl/com_accumulator.sv */
`timescale 1ns/1ns
`default_nettype none

module com_accumulator (
  input  wire                                       clk_65mhz,
  input  wire                                       sys_rst,
  input  wire                                       mask_valid,
  input  wire                                       mask,
  input  wire  [color_tracker_pkg::hcount_width-1:0] mask_hcount,
  input  wire  [color_tracker_pkg::vcount_width-1:0] mask_vcount,
  input  wire  [color_tracker_pkg::num_axes-1:0]     div_ack,
  output logic                                      div_req,
  output logic [color_tracker_pkg::num_axes-1:0][color_tracker_pkg::sum_width-1:0] div_dividend,
  output logic [color_tracker_pkg::sum_width-1:0]    div_divisor
);

  localparam int sw = color_tracker_pkg::sum_width;
  localparam int cw = color_tracker_pkg::count_width;

  logic [sw-1:0] x_sum, y_sum; // running sums for the current frame
  logic [cw-1:0] count;
  logic [sw-1:0] x_add, y_add; // this pixel's share
  logic [cw-1:0] cnt_add;
  logic hit; // valid and masked
  logic frame_start;
  logic req_open; // handshake not yet back to idle
  logic all_ack;
  logic launch;

  assign hit         = mask_valid && mask;
  assign frame_start = mask_valid && (mask_hcount == '0) && (mask_vcount == '0);
  assign req_open    = div_req || (|div_ack); // includes the ack-drop phase
  assign all_ack     = &div_ack;
  assign launch      = frame_start && (count != '0) && !req_open;

  assign x_add   = hit ? sw'(mask_hcount) : '0;
  assign y_add   = hit ? sw'(mask_vcount) : '0;
  assign cnt_add = hit ? cw'(1) : '0;

  // frame start pixel opens the new frame
  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      x_sum <= '0;
      y_sum <= '0;
      count <= '0;
    end else if (frame_start) begin
      x_sum <= x_add;
      y_sum <= y_add;
      count <= cnt_add;
    end else begin
      x_sum <= x_sum + x_add;
      y_sum <= y_sum + y_add;
      count <= count + cnt_add;
    end
  end

  // shared request lane, dividers start together
  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      div_req <= 1'b0;
    end else if (launch) begin
      div_req <= 1'b1;
    end else if (div_req && all_ack) begin
      div_req <= 1'b0; // every lane has answered
    end
  end

  // operands held stable while req is up
  always_ff @(posedge clk_65mhz) begin
    if (launch) begin
      div_dividend[0] <= x_sum;
      div_dividend[1] <= y_sum;
      div_divisor     <= sw'(count);
    end
  end

endmodule

`default_nettype wire

/* rtl/serial_divider.sv */
`timescale 1ns/1ns
`default_nettype none

module serial_divider #(
  parameter int WIDTH = 32
) (
  input  wire              clk_65mhz,
  input  wire              sys_rst,
  input  wire              div_req,
  input  wire  [WIDTH-1:0] dividend,
  input  wire  [WIDTH-1:0] divisor,
  output logic             div_ack,
  output logic [WIDTH-1:0] quotient
);

  localparam int cnt_width = $clog2(WIDTH);

  localparam logic [1:0] st_idle = 2'd0;
  localparam logic [1:0] st_run  = 2'd1; // one quotient bit per cycle
  localparam logic [1:0] st_ack  = 2'd2; // publish result, raise ack
  localparam logic [1:0] st_wait = 2'd3; // hold ack until req drops

  logic [1:0] state;
  logic [cnt_width-1:0] bit_cnt;
  logic [WIDTH-1:0] rem; // partial remainder, always below divisor
  logic [WIDTH-1:0] work; // dividend shifts out, quotient shifts in
  logic [WIDTH-1:0] dvs;
  logic [WIDTH:0] shifted;
  logic [WIDTH+1:0] diff;
  logic borrow;

  // trial subtract
  always_comb begin
    shifted = {rem, work[WIDTH-1]};
    diff    = {1'b0, shifted} - {2'b00, dvs};
    borrow  = diff[WIDTH+1];
  end

  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      state   <= st_idle;
      div_ack <= 1'b0;
    end else begin
      case (state)
        st_idle: if (div_req) state <= st_run;
        st_run:  if (bit_cnt == '0) state <= st_ack;
        st_ack: begin
          div_ack <= 1'b1;
          state   <= st_wait;
        end
        default: if (!div_req) begin // st_wait
          div_ack <= 1'b0;
          state   <= st_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk_65mhz) begin
    case (state)
      st_idle: begin
        rem     <= '0;
        work    <= dividend;
        dvs     <= divisor;
        bit_cnt <= cnt_width'(WIDTH - 1);
      end
      st_run: begin
        rem     <= borrow ? shifted[WIDTH-1:0] : diff[WIDTH-1:0]; // restore on borrow
        work    <= {work[WIDTH-2:0], ~borrow};
        bit_cnt <= bit_cnt - 1'b1;
      end
      st_ack:  quotient <= work; // stays put until next ack
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* rtl/com_collector.sv */
`timescale 1ns/1ns
`default_nettype none

module com_collector (
  input  wire                                       clk_65mhz,
  input  wire                                       sys_rst,
  input  wire  [color_tracker_pkg::num_axes-1:0]     div_ack,
  input  wire  [color_tracker_pkg::num_axes-1:0][color_tracker_pkg::sum_width-1:0] quotient,
  output logic                                      com_valid,
  output logic [color_tracker_pkg::hcount_width-1:0] x_com,
  output logic [color_tracker_pkg::vcount_width-1:0] y_com
);

  logic all_ack; // every lane done
  logic all_ack_q;
  logic all_rise;

  assign all_ack  = &div_ack;
  assign all_rise = all_ack && !all_ack_q; // first cycle of all-high

  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      all_ack_q <= 1'b0;
      com_valid <= 1'b0;
    end else begin
      all_ack_q <= all_ack;
      com_valid <= all_rise; // single pulse, cannot repeat back to back
    end
  end

  // last result held between frames
  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      x_com <= '0;
      y_com <= '0;
    end else if (all_rise) begin
      x_com <= quotient[0][color_tracker_pkg::hcount_width-1:0]; // lane 0 is x
      y_com <= quotient[1][color_tracker_pkg::vcount_width-1:0];
    end
  end

endmodule

`default_nettype wire

/* rtl/color_tracker_top.sv */
`timescale 1ns/1ns
`default_nettype none

module color_tracker_top (
  input  wire                                       clk_65mhz,
  input  wire                                       sys_rst,
  input  wire                                       pixel_valid,
  input  wire  [color_tracker_pkg::pixel_width-1:0]  pixel,
  input  wire  [color_tracker_pkg::hcount_width-1:0] hcount,
  input  wire  [color_tracker_pkg::vcount_width-1:0] vcount,
  input  wire  [2:0]                                chan_sel,
  input  wire  [color_tracker_pkg::chan_width-1:0]   lower_bound,
  input  wire  [color_tracker_pkg::chan_width-1:0]   upper_bound,
  output logic                                      mask_valid,
  output logic                                      mask,
  output logic [color_tracker_pkg::hcount_width-1:0] mask_hcount,
  output logic [color_tracker_pkg::vcount_width-1:0] mask_vcount,
  output logic                                      com_valid,
  output logic [color_tracker_pkg::hcount_width-1:0] x_com,
  output logic [color_tracker_pkg::vcount_width-1:0] y_com
);

  localparam int div_width = color_tracker_pkg::sum_width;

  // converter to threshold, 3 cycles after the pixel
  logic                                      conv_valid;
  logic [color_tracker_pkg::pixel_width-1:0]  conv_pixel;
  logic [color_tracker_pkg::hcount_width-1:0] conv_hcount;
  logic [color_tracker_pkg::vcount_width-1:0] conv_vcount;
  logic [7:0] y, cr, cb;

  // divider handshake
  logic                                          div_req;
  logic [color_tracker_pkg::num_axes-1:0]        div_ack;
  logic [color_tracker_pkg::num_axes-1:0][div_width-1:0] div_dividend;
  logic [div_width-1:0]                          div_divisor; // shared count
  logic [color_tracker_pkg::num_axes-1:0][div_width-1:0] div_quotient;

  ycrcb_converter u_conv (
    .clk_65mhz(clk_65mhz), .sys_rst(sys_rst),
    .in_valid(pixel_valid), .in_pixel(pixel), .in_hcount(hcount), .in_vcount(vcount),
    .out_valid(conv_valid), .out_pixel(conv_pixel),
    .out_hcount(conv_hcount), .out_vcount(conv_vcount),
    .y(y), .cr(cr), .cb(cb)
  );

  channel_threshold u_thresh (
    .clk_65mhz(clk_65mhz), .sys_rst(sys_rst),
    .in_valid(conv_valid), .in_pixel(conv_pixel),
    .in_hcount(conv_hcount), .in_vcount(conv_vcount),
    .y(y), .cr(cr), .cb(cb),
    .chan_sel(chan_sel), .lower_bound(lower_bound), .upper_bound(upper_bound),
    .mask_valid(mask_valid), .mask(mask),
    .mask_hcount(mask_hcount), .mask_vcount(mask_vcount)
  );

  com_accumulator u_accum (
    .clk_65mhz(clk_65mhz), .sys_rst(sys_rst),
    .mask_valid(mask_valid), .mask(mask),
    .mask_hcount(mask_hcount), .mask_vcount(mask_vcount),
    .div_ack(div_ack), .div_req(div_req),
    .div_dividend(div_dividend), .div_divisor(div_divisor)
  );

  // one lane per axis, all share the request
  for (genvar i = 0; i < color_tracker_pkg::num_axes; i++) begin : g_div
    serial_divider #(.WIDTH(div_width)) u_div (
      .clk_65mhz(clk_65mhz), .sys_rst(sys_rst),
      .div_req(div_req), .dividend(div_dividend[i]), .divisor(div_divisor),
      .div_ack(div_ack[i]), .quotient(div_quotient[i])
    );
  end

  com_collector u_collect (
    .clk_65mhz(clk_65mhz), .sys_rst(sys_rst),
    .div_ack(div_ack), .quotient(div_quotient),
    .com_valid(com_valid), .x_com(x_com), .y_com(y_com)
  );

endmodule

`default_nettype wire

/* tests/tb_clock_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
  output logic clk_65mhz,
  output logic sys_rst
);

  // 20 ns period
  initial begin
    clk_65mhz = 1'b0;
    forever #10 clk_65mhz = ~clk_65mhz;
  end

  initial begin
    sys_rst = 1'b1;
    repeat (2) @(posedge clk_65mhz); // two reset edges
    sys_rst <= 1'b0;
  end

endmodule

`default_nettype wire

/* tests/com_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module com_checker (
  input wire clk_65mhz,
  input wire sys_rst,
  input wire pixel_valid,
  input wire mask_valid,
  input wire com_valid
);

  int fail_cnt = 0; // read by the testbench at the end
  logic rst_seen = 1'b0; // at least one reset edge taken
  logic [2:0] run_cnt = '0; // cycles since reset, saturating

  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      run_cnt  <= '0;
      rst_seen <= 1'b1;
    end else if (run_cnt != 3'd7) begin
      run_cnt <= run_cnt + 3'd1;
    end
  end

  // pipeline depth is fixed
  a_mask_latency: assert property (@(posedge clk_65mhz) disable iff (sys_rst)
    (run_cnt >= 3'd4) |-> (mask_valid == $past(pixel_valid, color_tracker_pkg::mask_latency)))
    else begin
      fail_cnt++;
      $error("mask_valid did not follow pixel_valid by the pipeline depth");
    end

  a_com_pulse: assert property (@(posedge clk_65mhz) disable iff (sys_rst)
    com_valid |=> !com_valid)
    else begin
      fail_cnt++;
      $error("com_valid high on two cycles in a row");
    end

  // outputs quiet once a reset edge has been seen
  a_reset_quiet: assert property (@(posedge clk_65mhz)
    (sys_rst && rst_seen) |-> (!mask_valid && !com_valid))
    else begin
      fail_cnt++;
      $error("mask_valid or com_valid high during reset");
    end

endmodule

bind color_tracker_top com_checker u_chk (
  .clk_65mhz(clk_65mhz), .sys_rst(sys_rst), .pixel_valid(pixel_valid),
  .mask_valid(mask_valid), .com_valid(com_valid)
);

`default_nettype wire

/* tests/color_tracker_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module color_tracker_tb;

  localparam int frame_w     = 8;
  localparam int frame_h     = 6;
  localparam int drain_limit = 1000; // cycles to wait for outstanding results
  localparam int reset_limit = 20;

  logic clk_65mhz, sys_rst;
  logic                                      pixel_valid;
  logic [color_tracker_pkg::pixel_width-1:0]  pixel;
  logic [color_tracker_pkg::hcount_width-1:0] hcount;
  logic [color_tracker_pkg::vcount_width-1:0] vcount;
  logic [2:0]                                chan_sel;
  logic [color_tracker_pkg::chan_width-1:0]   lower_bound, upper_bound;
  logic                                      mask_valid, mask, com_valid;
  logic [color_tracker_pkg::hcount_width-1:0] mask_hcount, x_com;
  logic [color_tracker_pkg::vcount_width-1:0] mask_vcount, y_com;

  logic [31:0] data_lfsr, gap_lfsr, saved_lfsr; // pixel and gap streams share the seed
  logic [21:0] mask_q [$]; // {mask, hcount, vcount}
  logic [20:0] com_q [$];  // {x_com, y_com}
  logic [21:0] exp_m;
  logic [20:0] exp_c;
  int frame_x, frame_y, frame_cnt; // model sums of the open frame
  int seq_errs, mon_errs, mask_seen, com_seen, tests_run, tests_failed;
  bit timed_out;
  logic [2:0] sel;
  logic [3:0] lo, hi;

  tb_clock_gen u_clk (.clk_65mhz(clk_65mhz), .sys_rst(sys_rst));

  color_tracker_top u_dut (
    .clk_65mhz(clk_65mhz), .sys_rst(sys_rst),
    .pixel_valid(pixel_valid), .pixel(pixel), .hcount(hcount), .vcount(vcount),
    .chan_sel(chan_sel), .lower_bound(lower_bound), .upper_bound(upper_bound),
    .mask_valid(mask_valid), .mask(mask), .mask_hcount(mask_hcount), .mask_vcount(mask_vcount),
    .com_valid(com_valid), .x_com(x_com), .y_com(y_com)
  );

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1); // x^32+x^22+x^2+x+1
  endfunction

  // one lfsr step per bit
  function automatic logic [31:0] take_bits(input int n, input bit from_gaps);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      if (from_gaps) begin
        gap_lfsr = lfsr_step(gap_lfsr);
        val = {val[30:0], gap_lfsr[0]};
      end else begin
        data_lfsr = lfsr_step(data_lfsr);
        val = {val[30:0], data_lfsr[0]};
      end
    end
    return val;
  endfunction

  function automatic logic expected_mask(input logic [15:0] px, input logic [2:0] s,
                                         input logic [3:0] lb, input logic [3:0] ub);
    int r8, g8, b8, yv, crv, cbv;
    logic [3:0] inten;
    r8 = int'({px[15:11], 3'b000});
    g8 = int'({px[10:5], 2'b00});
    b8 = int'({px[4:0], 3'b000});
    yv  = (color_tracker_pkg::coef_y_r * r8 + color_tracker_pkg::coef_y_g * g8
           + color_tracker_pkg::coef_y_b * b8) >> 8;
    crv = ((color_tracker_pkg::coef_cr_r * r8 - color_tracker_pkg::coef_cr_g * g8
           - color_tracker_pkg::coef_cr_b * b8) >>> 8) + 128;
    cbv = ((color_tracker_pkg::coef_cb_b * b8 - color_tracker_pkg::coef_cb_r * r8
           - color_tracker_pkg::coef_cb_g * g8) >>> 8) + 128;
    case (s)
      color_tracker_pkg::chan_r:  inten = px[15:12];
      color_tracker_pkg::chan_g:  inten = px[10:7];
      color_tracker_pkg::chan_b:  inten = px[4:1];
      color_tracker_pkg::chan_y:  inten = 4'((yv & 255) >> 4);
      color_tracker_pkg::chan_cr: inten = 4'((crv & 255) >> 4); // kept as 8 bits
      color_tracker_pkg::chan_cb: inten = 4'((cbv & 255) >> 4);
      default:                    inten = 4'd0;
    endcase
    return (inten >= lb) && (inten <= ub); // inclusive both ends
  endfunction

  function automatic int error_total();
    return seq_errs + mon_errs + u_dut.u_chk.fail_cnt;
  endfunction

  // queue the mask, close the frame at (0,0)
  task automatic predict_pixel(input logic [15:0] px, input int x, input int v);
    logic m;
    m = expected_mask(px, chan_sel, lower_bound, upper_bound);
    mask_q.push_back({m, 11'(x), 10'(v)});
    if (x == 0 && v == 0) begin
      if (frame_cnt != 0) com_q.push_back({11'(frame_x / frame_cnt), 10'(frame_y / frame_cnt)});
      frame_x   = 0;
      frame_y   = 0;
      frame_cnt = 0;
    end
    if (m) begin
      frame_x += x;
      frame_y += v;
      frame_cnt++;
    end
  endtask

  task automatic send_frame(input int w, input int h, input bit gaps);
    int gap;
    logic [15:0] px;
    for (int v = 0; v < h; v++) begin
      for (int x = 0; x < w; x++) begin
        px  = 16'(take_bits(16, 1'b0));
        gap = gaps ? int'(take_bits(2, 1'b1)) : 0; // 0 to 3 idle cycles
        for (int g = 0; g < gap; g++) begin
          @(posedge clk_65mhz);
          pixel_valid <= 1'b0;
        end
        @(posedge clk_65mhz);
        pixel_valid <= 1'b1;
        pixel       <= px;
        hcount      <= 11'(x);
        vcount      <= 10'(v);
        predict_pixel(px, x, v);
      end
    end
    @(posedge clk_65mhz);
    pixel_valid <= 1'b0;
  endtask

  task automatic wait_drain(input string what);
    int n;
    int k;
    for (n = 0; n < drain_limit; n++) begin
      @(posedge clk_65mhz);
      if (mask_q.size() == 0 && com_q.size() == 0) break;
    end
    if (n == drain_limit) begin
      $display("timeout: %s never delivered every expected mask and centre of mass", what);
      seq_errs++;
      timed_out = 1'b1;
    end
    // dividers back to idle before the next frame start
    for (k = 0; k < drain_limit; k++) begin
      @(posedge clk_65mhz);
      if (!u_dut.div_req && (u_dut.div_ack == '0)) break;
    end
    if (k == drain_limit) begin
      $display("timeout: %s left the divider handshake open", what);
      seq_errs++;
      timed_out = 1'b1;
    end
  endtask

  task automatic finish_test(input string name, input int errs0, input int m0, input int c0);
    tests_run++;
    if (error_total() != errs0) tests_failed++;
    $display("%s: %0d masks, %0d com results, %0d errors", name, mask_seen - m0,
             com_seen - c0, error_total() - errs0);
  endtask

  task automatic check_reset_state();
    int errs0;
    errs0 = error_total();
    if (mask_valid !== 1'b0) begin
      $display("Error mask_valid: expected %h got %h", 1'b0, mask_valid);
      seq_errs++;
    end
    if (com_valid !== 1'b0) begin
      $display("Error com_valid: expected %h got %h", 1'b0, com_valid);
      seq_errs++;
    end
    if (x_com !== '0 || y_com !== '0) begin
      $display("Error x_com/y_com: expected %h/%h got %h/%h", 11'h0, 10'h0, x_com, y_com);
      seq_errs++;
    end
    finish_test("reset state", errs0, mask_seen, com_seen);
  endtask

  // frames, then a lone (0,0) pixel that closes the last one
  task automatic run_test(input string name, input logic [2:0] s, input logic [3:0] lb,
                          input logic [3:0] ub, input int frames, input bit gaps);
    int errs0, m0, c0;
    if (timed_out) return;
    errs0 = error_total();
    m0    = mask_seen;
    c0    = com_seen;
    @(posedge clk_65mhz);
    chan_sel    <= s;
    lower_bound <= lb;
    upper_bound <= ub;
    @(posedge clk_65mhz);
    for (int f = 0; f < frames; f++) send_frame(frame_w, frame_h, gaps);
    send_frame(1, 1, 1'b0);
    wait_drain(name);
    finish_test(name, errs0, m0, c0);
  endtask

  // compare outputs in order against the model queues
  always @(posedge clk_65mhz) begin
    if (!sys_rst && mask_valid) begin
      if (mask_q.size() == 0) begin
        $display("mask_valid rose with no pixel outstanding");
        mon_errs++;
      end else begin
        exp_m = mask_q.pop_front();
        mask_seen++;
        if (mask !== exp_m[21]) begin
          $display("Error mask: expected %h got %h", exp_m[21], mask);
          mon_errs++;
        end
        if (mask_hcount !== exp_m[20:10] || mask_vcount !== exp_m[9:0]) begin
          $display("Error mask_hcount/mask_vcount: expected %h/%h got %h/%h",
                   exp_m[20:10], exp_m[9:0], mask_hcount, mask_vcount);
          mon_errs++;
        end
      end
    end
    if (!sys_rst && com_valid) begin
      if (com_q.size() == 0) begin
        $display("com_valid pulsed with no frame result expected");
        mon_errs++;
      end else begin
        exp_c = com_q.pop_front();
        com_seen++;
        if (x_com !== exp_c[20:10] || y_com !== exp_c[9:0]) begin
          $display("Error x_com/y_com: expected %h/%h got %h/%h",
                   exp_c[20:10], exp_c[9:0], x_com, y_com);
          mon_errs++;
        end
      end
    end
  end

  initial begin
    int n;
    data_lfsr   = 32'h7fdd;
    gap_lfsr    = 32'h7fdd;
    pixel_valid = 1'b0;
    pixel       = '0;
    hcount      = '0;
    vcount      = '0;
    chan_sel    = 3'd0;
    lower_bound = 4'd0;
    upper_bound = 4'd15;
    for (n = 0; n < reset_limit; n++) begin
      @(posedge clk_65mhz);
      if (!sys_rst) break;
    end
    if (n == reset_limit) begin
      $display("timeout: sys_rst never went low");
      seq_errs++;
      timed_out = 1'b1;
    end
    @(posedge clk_65mhz);
    check_reset_state();
    for (int s = 0; s < 6; s++) begin
      lo = 4'(take_bits(3, 1'b0));
      hi = lo + 4'(take_bits(3, 1'b0)); // ordered window
      run_test($sformatf("channel %0d", s), 3'(s), lo, hi, 2, 1'b1);
    end
    run_test("bounds 0 to 15", 3'(take_bits(2, 1'b0)), 4'd0, 4'd15, 2, 1'b1);
    run_test("bounds inverted", color_tracker_pkg::chan_y, 4'd9, 4'd4, 3, 1'b1);
    for (int i = 0; i < 4; i++) begin
      sel = 3'(take_bits(3, 1'b0)); // codes 6 and 7 too
      lo  = 4'(take_bits(4, 1'b0));
      hi  = 4'(take_bits(4, 1'b0));
      run_test($sformatf("random bounds %0d", i), sel, lo, hi, 2, 1'b1);
    end
    // same pixel data with and without gaps
    saved_lfsr = data_lfsr;
    run_test("dense frames", color_tracker_pkg::chan_cr, 4'd5, 4'd10, 2, 1'b0);
    data_lfsr = saved_lfsr;
    run_test("gapped frames", color_tracker_pkg::chan_cr, 4'd5, 4'd10, 2, 1'b1);
    $display("%0d tests, %0d failed, %0d masks, %0d com results, %0d errors",
             tests_run, tests_failed, mask_seen, com_seen, error_total());
    if (error_total() == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* color_tracker.f */
rtl/color_tracker_pkg.sv
rtl/ycrcb_converter.sv
rtl/channel_threshold.sv
rtl/com_accumulator.sv
rtl/serial_divider.sv
rtl/com_collector.sv
rtl/color_tracker_top.sv
tests/tb_clock_gen.sv
tests/com_checker.sv
tests/color_tracker_tb.sv

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, then judge the log
LOG=sim.log
rm -f "$LOG"
verilator --binary --timing --assert -Wno-fatal -f color_tracker.f \
  --top-module color_tracker_tb -Mdir obj_dir -o color_tracker_sim > "$LOG" 2>&1 \
  && ./obj_dir/color_tracker_sim +verilator+error+limit+100 >> "$LOG" 2>&1 \
  || echo "build or simulation exited with an error" >> "$LOG"
cat "$LOG"
grep -q "Simulation PASSED" "$LOG" && ! grep -q "Simulation FAILED" "$LOG" && exit 0 || exit 1
